// ==== src.f ====
logic/nbbpu_pkg.sv
logic/instruction_decoder.sv
logic/register_file.sv
logic/alu.sv
logic/program_counter.sv
logic/datapath.sv
logic/store_port.sv
logic/nbbpu.sv
test/nbbpu_tb.sv

// ==== Bender.yml ====
package:
  name: nbbpu

sources:
  - logic/nbbpu_pkg.sv
  - logic/instruction_decoder.sv
  - logic/register_file.sv
  - logic/alu.sv
  - logic/program_counter.sv
  - logic/datapath.sv
  - logic/store_port.sv
  - logic/nbbpu.sv
  - target: test
    files:
      - test/nbbpu_tb.sv

// ==== test/nbbpu_tb.sv ====
// table-driven testbench for the nbbpu core with reference model, check task and watchdog
module nbbpu_tb;

    import nbbpu_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int RAND_PAIRS   = 10;     // random alu and store pairs

    logic  clock;
    logic  arst_n;
    word_t instruction;
    word_t read_data;
    logic  write_enable;
    word_t address;
    word_t write_data;
    word_t pc;
    logic  debug;

    // stimulus table with one instruction and one read_data per cycle
    word_t instr_table[$];
    word_t rdata_table[$];
    logic  table_ready = 1'b0;

    // reference model state
    word_t model_regs [NUM_REGS];
    word_t model_pc;
    logic  model_debug;

    integer seed = 32'h5cdf7cc1;

    nbbpu UUT (
        .clock       (clock),
        .arst_n      (arst_n),
        .instruction (instruction),
        .read_data   (read_data),
        .write_enable(write_enable),
        .address     (address),
        .write_data  (write_data),
        .pc          (pc),
        .debug       (debug)
    );

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic word_t encode_rrr(opcode_t op, reg_addr_t a, reg_addr_t b, reg_addr_t d);
        encode_rrr = {op, a, b, d};
    endfunction

    function automatic word_t encode_imm(opcode_t op, imm_t imm, reg_addr_t d);
        encode_imm = {op, imm, d};     // imm spans fields a and b
    endfunction

    task automatic add_entry(input word_t instr, input word_t rdata);
        instr_table.push_back(instr);
        rdata_table.push_back(rdata);
    endtask

    // compare one value against its expectation
    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ------------------------------------------------------------
    // reference model stepping one instruction per rising edge
    // ------------------------------------------------------------
    task automatic advance_model(input word_t instr, input word_t rdata);
        opcode_t   op;
        reg_addr_t fa;
        reg_addr_t fb;
        reg_addr_t fd;
        imm_t      imm;
        word_t     ra;
        word_t     rb;
        op  = opcode_t'(instr[15:12]);
        fa  = instr[11:8];
        fb  = instr[7:4];
        fd  = instr[3:0];
        imm = instr[11:4];
        ra  = model_regs[fa];       // values before this edge
        rb  = model_regs[fb];
        case (op)
            OP_AND:   model_regs[fd] = ra & rb;
            OP_OR:    model_regs[fd] = ra | rb;
            OP_ADD:   model_regs[fd] = ra + rb;            // 16-bit wrap
            OP_SUB:   model_regs[fd] = ra - rb;
            OP_SHR:   model_regs[fd] = ra >> rb[3:0];
            OP_SHL:   model_regs[fd] = ra << rb[3:0];
            OP_NOT:   model_regs[fd] = ~ra;
            OP_XOR:   model_regs[fd] = ra ^ rb;
            OP_SET:   model_regs[fd] = {8'h00, imm};
            OP_SETH:  model_regs[fd] = {imm, model_regs[fd][7:0]};
            OP_LOAD:  model_regs[fd] = rdata;
            OP_STORE: model_debug = rb[15] ? ~model_debug : model_debug;
            default:  ;                                    // jump, beq, nop
        endcase
        if (op == OP_JUMP)
            model_pc = ra;
        else if (op == OP_BEQ && ra == rb)
            model_pc = model_pc + {{12{fd[3]}}, fd};      // signed word offset
        else
            model_pc = model_pc + 16'd1;
    endtask

    // ------------------------------------------------------------
    // clock and watchdog
    // ------------------------------------------------------------
    initial
    begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial
    begin
        wait (table_ready);
        #((RESET_CYCLES + instr_table.size() + 20) * CLK_PERIOD);
        $display("timeout: the test did not finish in the expected time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------
    // table build
    // ------------------------------------------------------------
    task automatic build_table();
        reg_addr_t a;
        reg_addr_t b;
        reg_addr_t d;
        opcode_t   op;
        add_entry(encode_rrr(OP_STORE, 4'd0, 4'd3, 4'd0), 16'h0000);   // cleared r3
        add_entry(encode_imm(OP_SET,  8'h12, 4'd1), 16'h0000);
        add_entry(encode_imm(OP_SETH, 8'hab, 4'd1), 16'h0000);          // r1 = ab12
        add_entry(encode_rrr(OP_STORE, 4'd0, 4'd1, 4'd0), 16'h0000);   // msb set
        add_entry(encode_imm(OP_SET,  8'hff, 4'd2), 16'h0000);
        add_entry(encode_rrr(OP_STORE, 4'd0, 4'd2, 4'd0), 16'h0000);   // no toggle
        add_entry(encode_imm(OP_SET,  8'h01, 4'd4), 16'h0000);
        add_entry(encode_imm(OP_SETH, 8'hff, 4'd5), 16'h0000);          // r5 = ff00
        add_entry(encode_imm(OP_SET,  8'hff, 4'd6), 16'h0000);
        add_entry(encode_imm(OP_SETH, 8'hff, 4'd6), 16'h0000);          // r6 = ffff
        add_entry(encode_rrr(OP_ADD, 4'd6, 4'd4, 4'd7), 16'h0000);     // wraps to 0
        add_entry(encode_rrr(OP_STORE, 4'd0, 4'd7, 4'd0), 16'h0000);
        add_entry(encode_rrr(OP_SUB, 4'd0, 4'd4, 4'd8), 16'h0000);     // wraps to ffff
        add_entry(encode_rrr(OP_STORE, 4'd0, 4'd8, 4'd0), 16'h0000);
        add_entry(encode_rrr(OP_AND, 4'd1, 4'd5, 4'd9), 16'h0000);
        add_entry(encode_rrr(OP_OR,  4'd1, 4'd2, 4'd10), 16'h0000);
        add_entry(encode_rrr(OP_XOR, 4'd1, 4'd5, 4'd11), 16'h0000);
        add_entry(encode_rrr(OP_NOT, 4'd1, 4'd0, 4'd12), 16'h0000);
        add_entry(encode_rrr(OP_STORE, 4'd0, 4'd9, 4'd0), 16'h0000);
        add_entry(encode_rrr(OP_STORE, 4'd0, 4'd10, 4'd0), 16'h0000);
        add_entry(encode_rrr(OP_STORE, 4'd0, 4'd11, 4'd0), 16'h0000);
        add_entry(encode_rrr(OP_STORE, 4'd0, 4'd12, 4'd0), 16'h0000);
        add_entry(encode_imm(OP_SET, 8'h0f, 4'd13), 16'h0000);          // shift of 15
        add_entry(encode_rrr(OP_SHR, 4'd6, 4'd0, 4'd14), 16'h0000);    // shift of 0
        add_entry(encode_rrr(OP_SHL, 4'd4, 4'd13, 4'd15), 16'h0000);
        add_entry(encode_rrr(OP_SHR, 4'd5, 4'd13, 4'd3), 16'h0000);
        add_entry(encode_rrr(OP_STORE, 4'd0, 4'd14, 4'd0), 16'h0000);
        add_entry(encode_rrr(OP_STORE, 4'd0, 4'd15, 4'd0), 16'h0000);
        add_entry(encode_rrr(OP_STORE, 4'd0, 4'd3, 4'd0), 16'h0000);
        add_entry(encode_imm(OP_SET, 8'h40, 4'd2), 16'h0000);           // load address
        add_entry(encode_rrr(OP_LOAD, 4'd2, 4'd0, 4'd9), 16'hc3a5);
        add_entry(encode_rrr(OP_STORE, 4'd2, 4'd9, 4'd0), 16'h0000);   // loaded value
        add_entry(encode_imm(OP_SET, 8'h20, 4'd10), 16'h0000);
        add_entry(encode_rrr(OP_JUMP, 4'd10, 4'd0, 4'd0), 16'h0000);
        add_entry(encode_rrr(OP_BEQ, 4'd0, 4'd7, 4'd5), 16'h0000);     // taken by +5
        add_entry(encode_rrr(OP_BEQ, 4'd0, 4'd4, 4'd3), 16'h0000);     // not taken
        add_entry(encode_rrr(OP_BEQ, 4'd4, 4'd4, 4'hd), 16'h0000);     // taken by -3
        add_entry(encode_rrr(OP_BEQ, 4'd1, 4'd1, 4'd0), 16'h0000);     // offset 0
        add_entry(encode_rrr(OP_NOP, 4'd0, 4'd0, 4'd0), 16'h0000);
        add_entry(16'hf000, 16'h0000);                                  // spare opcode
        add_entry(encode_rrr(OP_STORE, 4'd1, 4'd1, 4'd0), 16'h0000);
        // random alu op followed by a store of its destination
        for (int i = 0; i < RAND_PAIRS; i++)
        begin
            op = opcode_t'({1'b0, 3'($random(seed))});
            a  = 4'($random(seed));
            b  = 4'($random(seed));
            d  = 4'($random(seed));
            add_entry(encode_rrr(op, a, b, d), 16'($random(seed)));
            a  = 4'($random(seed));
            add_entry(encode_rrr(OP_STORE, a, d, 4'd0), 16'($random(seed)));
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial
    begin
        word_t   instr;
        opcode_t op;
        arst_n      = 1'b0;
        instruction = encode_rrr(OP_NOP, 4'd0, 4'd0, 4'd0);
        read_data   = '0;
        for (int r = 0; r < NUM_REGS; r++)
            model_regs[r] = '0;
        model_pc    = RESET_PC;
        model_debug = 1'b1;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);

        for (int i = 0; i < instr_table.size(); i++)
        begin
            @(negedge clock);
            arst_n      = 1'b1;
            instr       = instr_table[i];
            instruction = instr;
            read_data   = rdata_table[i];
            op          = opcode_t'(instr[15:12]);
            #(CLK_PERIOD / 4);      // combinational outputs settled
            check_value("pc", model_pc, pc);
            check_value("debug", {15'd0, model_debug}, {15'd0, debug});
            check_value("write_enable", {15'd0, op == OP_STORE}, {15'd0, write_enable});
            if (op == OP_LOAD || op == OP_STORE)
            begin
                check_value("address", model_regs[instr[11:8]], address);
                check_value("write_data", model_regs[instr[7:4]], write_data);
            end
            @(posedge clock);
            advance_model(instr, rdata_table[i]);
        end

        @(negedge clock);
        check_value("pc", model_pc, pc);            // last edge effects
        check_value("debug", {15'd0, model_debug}, {15'd0, debug});
        $display("Test OK");
        $finish;
    end

endmodule

// ==== logic/nbbpu.sv ====
// single-cycle 16-bit core top level joining decoder, datapath and store port
module nbbpu
(
    input  logic             clock,
    input  logic             arst_n,
    input  nbbpu_pkg::word_t instruction,   // from instruction memory at pc
    input  nbbpu_pkg::word_t read_data,     // from data memory at address
    output logic             write_enable,
    output nbbpu_pkg::word_t address,
    output nbbpu_pkg::word_t write_data,
    output nbbpu_pkg::word_t pc,
    output logic             debug
);

    import nbbpu_pkg::*;

    // ------------------------------------------------------------
    // internal wires
    // ------------------------------------------------------------
    ctrl_t ctrl;            // decoded control, one driver
    word_t dp_address;      // reg a value
    word_t dp_store_data;   // reg b value

    // ------------------------------------------------------------
    // input side
    // ------------------------------------------------------------
    instruction_decoder u_instruction_decoder (
        .opcode(opcode_t'(instruction[15:12])),
        .ctrl  (ctrl)
    );

    // ------------------------------------------------------------
    // processing
    // ------------------------------------------------------------
    datapath u_datapath (
        .clock      (clock),
        .arst_n     (arst_n),
        .instruction(instruction),
        .ctrl       (ctrl),
        .read_data  (read_data),
        .address    (dp_address),
        .store_data (dp_store_data),
        .pc         (pc)
    );

    // ------------------------------------------------------------
    // output side
    // ------------------------------------------------------------
    store_port u_store_port (
        .clock       (clock),
        .arst_n      (arst_n),
        .ctrl        (ctrl),
        .address_in  (dp_address),
        .store_data  (dp_store_data),
        .write_enable(write_enable),
        .address     (address),
        .write_data  (write_data),
        .debug       (debug)
    );

endmodule

// ==== logic/store_port.sv ====
// data memory write port and store-driven debug toggle flag
module store_port
(
    input  logic             clock,
    input  logic             arst_n,
    input  nbbpu_pkg::ctrl_t ctrl,
    input  nbbpu_pkg::word_t address_in,    // reg a from datapath
    input  nbbpu_pkg::word_t store_data,    // reg b from datapath
    output logic             write_enable,
    output nbbpu_pkg::word_t address,
    output nbbpu_pkg::word_t write_data,
    output logic             debug
);

    logic toggle;   // store with msb set this cycle

    // ------------------------------------------------------------
    // memory port, combinational
    // ------------------------------------------------------------
    assign write_enable = ctrl.mem_write;
    assign address      = address_in;      // also used for loads
    assign write_data   = store_data;

    // ------------------------------------------------------------
    // debug flag
    // ------------------------------------------------------------
    assign toggle = ctrl.mem_write & store_data[15];

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            debug <= 1'b1;      // starts high
        end
        else if (toggle)
        begin
            debug <= ~debug;
        end
    end

endmodule

// ==== logic/datapath.sv ====
// processing core with register file, ALU, program counter and write-back select
module datapath
(
    input  logic             clock,
    input  logic             arst_n,
    input  nbbpu_pkg::word_t instruction,
    input  nbbpu_pkg::ctrl_t ctrl,
    input  nbbpu_pkg::word_t read_data,     // from data memory, same cycle
    output nbbpu_pkg::word_t address,       // reg a value
    output nbbpu_pkg::word_t store_data,    // reg b value
    output nbbpu_pkg::word_t pc
);

    import nbbpu_pkg::*;

    // ------------------------------------------------------------
    // instruction fields
    // ------------------------------------------------------------
    reg_addr_t field_a;
    reg_addr_t field_b;
    reg_addr_t field_d;
    imm_t      imm;

    assign field_a = instruction[11:8];
    assign field_b = instruction[7:4];
    assign field_d = instruction[3:0];     // dest, or branch offset
    assign imm     = instruction[11:4];    // overlaps a and b

    reg_addr_t read_addr_a;
    word_t     reg_a;
    word_t     reg_b;
    word_t     alu_result;
    logic      equal;
    logic      wb_enable;
    word_t     wb_value;

    // seth needs the old d value, and field a holds immediate bits anyway
    assign read_addr_a = (ctrl.reg_set && ctrl.set_high) ? field_d : field_a;

    // ------------------------------------------------------------
    // write-back select
    // ------------------------------------------------------------
    assign wb_enable = ctrl.reg_write | ctrl.reg_set | ctrl.mem_read;

    always_comb
    begin
        if (ctrl.mem_read)
        begin
            wb_value = read_data;                       // load
        end
        else if (ctrl.reg_set)
        begin
            wb_value = ctrl.set_high ? {imm, reg_a[7:0]}    // seth, low byte kept
                                     : {8'h00, imm};        // set
        end
        else
        begin
            wb_value = alu_result;
        end
    end

    // ------------------------------------------------------------
    // sub-blocks
    // ------------------------------------------------------------
    register_file u_register_file (
        .clock       (clock),
        .arst_n      (arst_n),
        .read_addr_a (read_addr_a),
        .read_addr_b (field_b),
        .read_data_a (reg_a),
        .read_data_b (reg_b),
        .write_enable(wb_enable),
        .write_addr  (field_d),
        .write_value (wb_value)
    );

    alu u_alu (.op(ctrl.alu_op), .operand_a(reg_a), .operand_b(reg_b),
               .result(alu_result), .equal(equal));

    program_counter u_program_counter (.clock(clock), .arst_n(arst_n), .ctrl(ctrl),
        .equal(equal), .jump_target(reg_a), .offset(field_d), .pc(pc));

    assign address    = reg_a;   // load/store address, also jump target
    assign store_data = reg_b;

endmodule

// ==== logic/program_counter.sv ====
// program counter register with sequential, jump and branch next-address select
module program_counter
(
    input  logic                 clock,
    input  logic                 arst_n,
    input  nbbpu_pkg::ctrl_t     ctrl,
    input  logic                 equal,         // from alu compare
    input  nbbpu_pkg::word_t     jump_target,   // reg a value
    input  nbbpu_pkg::reg_addr_t offset,        // d field, signed words
    output nbbpu_pkg::word_t     pc
);

    import nbbpu_pkg::*;

    word_t offset_ext;  // sign-extended branch offset
    word_t pc_next;

    // -8..+7 words relative to the branch itself
    assign offset_ext = {{($bits(word_t) - $bits(reg_addr_t)){offset[3]}}, offset};

    // ------------------------------------------------------------
    // next address
    // ------------------------------------------------------------
    always_comb
    begin
        if (ctrl.jump)
        begin
            pc_next = jump_target;              // absolute
        end
        else if (ctrl.branch && equal)
        begin
            pc_next = pc + offset_ext;          // taken beq, wraps
        end
        else
        begin
            pc_next = pc + word_t'(1);          // fall through
        end
    end

    // ------------------------------------------------------------
    // pc register
    // ------------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc <= RESET_PC;
        end
        else
        begin
            pc <= pc_next;
        end
    end

endmodule

// ==== logic/alu.sv ====
// combinational ALU for the register operations and the branch compare
module alu
(
    input  logic [2:0]       op,         // opcode bits 2..0
    input  nbbpu_pkg::word_t operand_a,
    input  nbbpu_pkg::word_t operand_b,
    output nbbpu_pkg::word_t result,
    output logic             equal       // a == b, for beq
);

    logic [3:0] shamt;      // shift distance, 0..15

    assign shamt = operand_b[3:0];  // upper bits of b ignored

    // ------------------------------------------------------------
    // operation select
    // ------------------------------------------------------------
    // all eight codes are used, so no default is needed
    always_comb
    begin
        case (op)
            3'd0:
            begin
                result = operand_a & operand_b;         // and
            end
            3'd1:
            begin
                result = operand_a | operand_b;         // or
            end
            3'd2:
            begin
                result = operand_a + operand_b;         // add, wraps
            end
            3'd3:
            begin
                result = operand_a - operand_b;         // sub, wraps
            end
            3'd4:
            begin
                result = operand_a >> shamt;            // logical, zero fill
            end
            3'd5:
            begin
                result = operand_a << shamt;
            end
            3'd6:
            begin
                result = ~operand_a;                    // b unused
            end
            3'd7:
            begin
                result = operand_a ^ operand_b;         // xor
            end
        endcase
    end

    // branch compare runs regardless of op
    assign equal = (operand_a == operand_b);

endmodule

// ==== logic/register_file.sv ====
// general purpose register file, two combinational reads and one clocked write
module register_file
(
    input  logic                clock,
    input  logic                arst_n,
    input  nbbpu_pkg::reg_addr_t read_addr_a,   // port a index
    input  nbbpu_pkg::reg_addr_t read_addr_b,   // port b index
    output nbbpu_pkg::word_t     read_data_a,
    output nbbpu_pkg::word_t     read_data_b,
    input  logic                write_enable,
    input  nbbpu_pkg::reg_addr_t write_addr,
    input  nbbpu_pkg::word_t     write_value
);

    import nbbpu_pkg::*;

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------
    word_t regs [NUM_REGS];     // r0 is an ordinary register here

    // ------------------------------------------------------------
    // write port
    // ------------------------------------------------------------
    // whole array clears on reset so programs start from known zeros
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (write_enable)
        begin
            regs[write_addr] <= write_value;    // visible next cycle
        end
    end

    // ------------------------------------------------------------
    // read ports
    // ------------------------------------------------------------
    // no bypass, a same-cycle write is not seen
    always_comb
    begin
        read_data_a = regs[read_addr_a];
        read_data_b = regs[read_addr_b];
    end

endmodule

// ==== logic/instruction_decoder.sv ====
// opcode decoder producing the per-instruction control bundle
module instruction_decoder
(
    input  nbbpu_pkg::opcode_t opcode,  // instruction bits 15..12
    output nbbpu_pkg::ctrl_t   ctrl     // control to datapath and store port
);

    import nbbpu_pkg::*;

    // ------------------------------------------------------------
    // purely combinational decode
    // ------------------------------------------------------------
    always_comb
    begin
        ctrl = '0;  // everything off unless the opcode says otherwise

        case (opcode)
            // register ops, alu op is the low part of the opcode
            OP_AND, OP_OR, OP_ADD, OP_SUB,
            OP_SHR, OP_SHL, OP_NOT, OP_XOR:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = opcode[2:0];
            end

            OP_SET:
            begin
                ctrl.reg_set = 1'b1;    // low byte, zero-extended
            end

            OP_SETH:
            begin
                ctrl.reg_set  = 1'b1;
                ctrl.set_high = 1'b1;   // keeps low byte of d
            end

            OP_LOAD:
            begin
                ctrl.mem_read = 1'b1;   // address from reg a
            end

            OP_STORE:
            begin
                ctrl.mem_write = 1'b1;  // data from reg b
            end

            OP_JUMP:
            begin
                ctrl.jump = 1'b1;
            end

            OP_BEQ:
            begin
                ctrl.branch = 1'b1;     // taken only when a == b
            end

            // nop and the spare opcode fall through as all-zero
            default:
            begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== logic/nbbpu_pkg.sv ====
// shared word and field types, opcode enum, control struct and core constants
package nbbpu_pkg;

    // ------------------------------------------------------------
    // core sizing
    // ------------------------------------------------------------
    localparam int NUM_REGS = 16;           // register file depth

    // ------------------------------------------------------------
    // basic types
    // ------------------------------------------------------------
    typedef logic [15:0] word_t;            // data, address and instruction word
    typedef logic [3:0]  reg_addr_t;        // register index, also the d field
    typedef logic [7:0]  imm_t;             // immediate byte, instruction bits 11..4

    localparam word_t RESET_PC = '0;        // first fetch address after reset

    // opcode in instruction bits 15..12
    // the low three bits of an ALU opcode double as the ALU operation
    typedef enum logic [3:0] {
        OP_AND   = 4'd0,
        OP_OR    = 4'd1,
        OP_ADD   = 4'd2,
        OP_SUB   = 4'd3,
        OP_SHR   = 4'd4,    // logical shift right
        OP_SHL   = 4'd5,
        OP_NOT   = 4'd6,    // operand b ignored
        OP_XOR   = 4'd7,
        OP_SET   = 4'd8,    // d = zero-extended imm
        OP_SETH  = 4'd9,    // d high byte = imm
        OP_LOAD  = 4'd10,
        OP_STORE = 4'd11,
        OP_JUMP  = 4'd12,
        OP_BEQ   = 4'd13,
        OP_NOP   = 4'd14    // 15 unused, also treated as nop
    } opcode_t;

    // ------------------------------------------------------------
    // decoded control, one bundle per instruction
    // ------------------------------------------------------------
    typedef struct packed {
        logic       reg_write;  // alu result -> reg d
        logic       reg_set;    // immediate -> reg d
        logic       set_high;   // immediate into high byte
        logic       mem_read;   // read_data -> reg d
        logic       mem_write;  // store to data memory
        logic       jump;       // pc <= reg a
        logic       branch;     // pc += offset if a == b
        logic [2:0] alu_op;     // alu operation select
    } ctrl_t;

endpackage
